// ==== filelist.f ====
src/boardPkg.sv
src/positionWriter.sv
src/boardMemory.sv
src/boxScanner.sv
src/boxRasterizer.sv
src/boardRenderer.sv
testbench/boardRenderer_chk.sv
testbench/boardRendererTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the boardRenderer testbench with Verilator, log in sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module boardRendererTb \
    -o VboardRendererTb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/VboardRendererTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== testbench/boardRendererTb.sv ====
// PixelCredits fixed at 4; positions only change after a frame's first pixel and the run spans 8 frames
`default_nettype none
`timescale 1ns/100ps

module boardRendererTb;

    localparam int PixelCredits = 4;
    localparam int BoardSize = boardPkg::BoardSize;
    localparam int BoxPixels = boardPkg::BoxSize * boardPkg::BoxSize;
    localparam int FramePixels = boardPkg::BoxCount * BoxPixels;
    // about 1.5 cycles per pixel at the worst delay over 8 frames
    // pauses in two frames still leave about 4x margin
    localparam int CycleLimit = 1_500_000;

    logic clock = 1'b0;
    logic reset = 1'b1;
    // first frame has red at column 3 row 5 and blue at column 12 row 0
    logic [boardPkg::PosWidth-1:0] redX = 4'd3;
    logic [boardPkg::PosWidth-1:0] redY = 4'd5;
    logic [boardPkg::PosWidth-1:0] blueX = 4'd12;
    logic [boardPkg::PosWidth-1:0] blueY = 4'd0;
    logic pixelCredit = 1'b0;
    logic pixelValid;
    logic [boardPkg::PixelWidth-1:0] pixelX;
    logic [boardPkg::PixelWidth-1:0] pixelY;
    logic [boardPkg::ColourWidth-1:0] pixelColour;
    logic endOfFrame;

    // sink model
    int cycle = 0;
    logic sinkHold = 1'b1;
    logic randomPauses = 1'b0;
    int dueCycles [$];
    int returnIndex = 0;
    int pauseLeft = 0;
    // reference model and frame bookkeeping
    int pixelsSeen = 0;
    int creditsSeen = 0;
    int framesStarted = 0;
    int framesDone = 0;
    int frameIndex = 0;
    int frameRedX;
    int frameRedY;
    int frameBlueX;
    int frameBlueY;
    int redCount;
    int blueCount;
    int noneCount;
    logic [boardPkg::ColourWidth-1:0] frameBoxColour [boardPkg::BoxCount];

    boardRenderer #(
        .PixelCredits(PixelCredits)
    ) u_dut (
        .clock(clock),
        .reset(reset),
        .redX(redX),
        .redY(redY),
        .blueX(blueX),
        .blueY(blueY),
        .pixelCredit(pixelCredit),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .endOfFrame(endOfFrame)
    );

    initial begin
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] observed);
        if (observed !== expected) begin
            failRun($sformatf("Fail %s: expected 0x%0h, observed 0x%0h",
                              name, expected, observed));
        end
    endtask

    // a shared box shows none like any other empty box
    function automatic logic [boardPkg::ColourWidth-1:0] boxColourFor(
        input int box, input int rx, input int ry, input int bx, input int by);
        int redBox;
        int blueBox;
        redBox = ry * BoardSize + rx;
        blueBox = by * BoardSize + bx;
        if (redBox == blueBox) begin
            return boardPkg::ColourNone;
        end
        if (box == redBox) begin
            return boardPkg::ColourRed;
        end
        return (box == blueBox) ? boardPkg::ColourBlue : boardPkg::ColourNone;
    endfunction

    ////////////////////////////////////////
    // cycle count and timeout
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= CycleLimit) begin
            failRun($sformatf("timeout after %0d cycles, the frames never finished", cycle));
        end
    end

    // one credit per pixel after 0 to 3 cycles and none while held or paused
    always @(posedge clock) begin
        if (reset) begin
            pixelCredit <= 1'b0;
        end else begin
            if (randomPauses && pauseLeft == 0 && ($urandom % 64) == 0) begin
                pauseLeft = 8 + int'($urandom % 24);
            end
            if (pauseLeft > 0) begin
                pauseLeft = pauseLeft - 1;
                pixelCredit <= 1'b0;
            end else if (!sinkHold && returnIndex < dueCycles.size()
                         && dueCycles[returnIndex] <= cycle) begin
                pixelCredit <= 1'b1;
                returnIndex = returnIndex + 1;
            end else begin
                pixelCredit <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // pixel monitor against the model
    ////////////////////////////////////////

    // outputs have settled by the falling edge
    always @(negedge clock) begin : monitor
        int box;
        int inner;
        int expectX;
        int expectY;
        logic [boardPkg::ColourWidth-1:0] expectColour;
        if (reset) begin
            check("pixelValid", 0, pixelValid);
        end else begin
            if (pixelValid) begin
                pixelsSeen = pixelsSeen + 1;
                // credits of this cycle not yet usable by the design
                if (pixelsSeen - creditsSeen > PixelCredits) begin
                    failRun("more pixels outstanding at the sink than PixelCredits");
                end
                // positions are stable from sampling until here
                if (frameIndex == 0) begin
                    frameRedX = int'(redX);
                    frameRedY = int'(redY);
                    frameBlueX = int'(blueX);
                    frameBlueY = int'(blueY);
                    redCount = 0;
                    blueCount = 0;
                    noneCount = 0;
                    framesStarted = framesStarted + 1;
                end
                // box order with rows of 10 inside each box
                box = frameIndex / BoxPixels;
                inner = frameIndex % BoxPixels;
                expectX = (box % BoardSize) * boardPkg::BoxSize + inner % boardPkg::BoxSize;
                expectY = (box / BoardSize) * boardPkg::BoxSize + inner / boardPkg::BoxSize;
                expectColour = boxColourFor(box, frameRedX, frameRedY, frameBlueX, frameBlueY);
                check("pixelX", expectX, pixelX);
                check("pixelY", expectY, pixelY);
                check("pixelColour", expectColour, pixelColour);
                check("endOfFrame", frameIndex == FramePixels - 1, endOfFrame);
                if (inner == 0) begin
                    frameBoxColour[box] = pixelColour;
                end
                if (pixelColour == boardPkg::ColourRed) begin
                    redCount = redCount + 1;
                end else if (pixelColour == boardPkg::ColourBlue) begin
                    blueCount = blueCount + 1;
                end else begin
                    noneCount = noneCount + 1;
                end
                dueCycles.push_back(cycle + int'($urandom % 4));
                if (frameIndex == FramePixels - 1) begin
                    frameIndex = 0;
                    framesDone = framesDone + 1;
                end else begin
                    frameIndex = frameIndex + 1;
                end
            end else begin
                check("endOfFrame", 0, endOfFrame);
            end
            if (pixelCredit) begin
                creditsSeen = creditsSeen + 1;
            end
        end
    end

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic setPositions(input int rx, input int ry, input int bx, input int by);
        @(posedge clock);
        redX <= boardPkg::PosWidth'(rx);
        redY <= boardPkg::PosWidth'(ry);
        blueX <= boardPkg::PosWidth'(bx);
        blueY <= boardPkg::PosWidth'(by);
    endtask

    task automatic waitFrameStart();
        int target;
        target = framesStarted + 1;
        wait (framesStarted >= target);
    endtask

    task automatic waitFramesDone(input int count);
        int target;
        target = framesDone + count;
        wait (framesDone >= target);
    endtask

    // sink withholds credits so only the initial ones get spent
    task automatic holdCredits();
        wait (pixelsSeen >= PixelCredits);
        repeat (50) @(posedge clock);
        check("pixelsSeen", PixelCredits, pixelsSeen);
    endtask

    task automatic renderFrame();
        sinkHold <= 1'b0;
        waitFramesDone(1);
        check("pixelsSeen", FramePixels, pixelsSeen);
        check("redCount", BoxPixels, redCount);
        check("blueCount", BoxPixels, blueCount);
        check("redBox", boardPkg::ColourRed, frameBoxColour[5 * BoardSize + 3]);
        check("blueBox", boardPkg::ColourBlue, frameBoxColour[0 * BoardSize + 12]);
    endtask

    // both players in one box leave the board blank
    task automatic sharedBox();
        waitFrameStart();
        setPositions(7, 7, 7, 7);
        waitFramesDone(2);
        check("noneCount", FramePixels, noneCount);
    endtask

    // moves land one frame later and the sweep clears the old boxes
    task automatic moveAndClear();
        waitFrameStart();
        setPositions(2, 9, 10, 4);
        waitFramesDone(1);
        waitFrameStart();
        setPositions(14, 1, 0, 13);
        waitFramesDone(1);
        check("redBox", boardPkg::ColourRed, frameBoxColour[9 * BoardSize + 2]);
        check("blueBox", boardPkg::ColourBlue, frameBoxColour[4 * BoardSize + 10]);
        waitFramesDone(1);
        check("oldRedBox", boardPkg::ColourNone, frameBoxColour[9 * BoardSize + 2]);
        check("oldBlueBox", boardPkg::ColourNone, frameBoxColour[4 * BoardSize + 10]);
        check("redBox", boardPkg::ColourRed, frameBoxColour[1 * BoardSize + 14]);
        check("blueBox", boardPkg::ColourBlue, frameBoxColour[13 * BoardSize + 0]);
    endtask

    task automatic randomBackpressure();
        randomPauses <= 1'b1;
        waitFrameStart();
        setPositions(15, 15, 0, 0);
        waitFramesDone(2);
        randomPauses <= 1'b0;
        check("redCount", BoxPixels, redCount);
        check("blueCount", BoxPixels, blueCount);
        check("redBox", boardPkg::ColourRed, frameBoxColour[boardPkg::BoxCount - 1]);
        check("blueBox", boardPkg::ColourBlue, frameBoxColour[0]);
    endtask

    initial begin : main
        void'($urandom(32'h7aae));
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        holdCredits();
        renderFrame();
        sharedBox();
        moveAndClear();
        randomBackpressure();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/boardRenderer_chk.sv ====
// checks the port traffic only; the credit count is rebuilt from pixelValid and pixelCredit
`default_nettype none
`timescale 1ns/100ps

module boardRendererChk #(
    parameter int PixelCredits = 4
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 pixelValid,
    input  logic                                 pixelCredit,
    input  logic [boardPkg::PixelWidth-1:0]      pixelX,
    input  logic [boardPkg::PixelWidth-1:0]      pixelY
);

    // 160 px per board side
    localparam int BoardPixels = boardPkg::BoardSize * boardPkg::BoxSize;

    // credits the design should hold right now
    int creditsHeld;

    always_ff @(posedge clock) begin
        if (reset) begin
            creditsHeld <= PixelCredits;
        end else begin
            creditsHeld <= creditsHeld + int'(pixelCredit) - int'(pixelValid);
        end
    end

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    // no pixel on an empty counter
    noPixelWithoutCredit: assert property (
        @(posedge clock) disable iff (reset) pixelValid |-> (creditsHeld > 0)
    ) else $error("pixel sent while the design held no credit");

    // coordinates stay on the board
    coordinateRange: assert property (
        @(posedge clock) disable iff (reset)
        pixelValid |-> (pixelX < BoardPixels) && (pixelY < BoardPixels)
    ) else $error("pixel coordinate outside the 160 x 160 board");

    // once a reset edge has passed
    quietInReset: assert property (
        @(posedge clock) reset && $past(reset) |-> !pixelValid
    ) else $error("pixelValid high during reset");

endmodule

bind boardRenderer boardRendererChk #(
    .PixelCredits(PixelCredits)
) u_chk (
    .clock(clock),
    .reset(reset),
    .pixelValid(pixelValid),
    .pixelCredit(pixelCredit),
    .pixelX(pixelX),
    .pixelY(pixelY)
);

`default_nettype wire

// ==== src/boardRenderer.sv ====
// positions must stay stable from sampling to the first pixel; pixelCredit returns one credit per pixel
`default_nettype none
`timescale 1ns/100ps

module boardRenderer #(
    parameter int PixelCredits = 4
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [boardPkg::PosWidth-1:0]        redX,
    input  logic [boardPkg::PosWidth-1:0]        redY,
    input  logic [boardPkg::PosWidth-1:0]        blueX,
    input  logic [boardPkg::PosWidth-1:0]        blueY,
    input  logic                                 pixelCredit,
    output logic                                 pixelValid,
    output logic [boardPkg::PixelWidth-1:0]      pixelX,
    output logic [boardPkg::PixelWidth-1:0]      pixelY,
    output logic [boardPkg::ColourWidth-1:0]     pixelColour,
    output logic                                 endOfFrame
);

    // writer to memory
    logic writeEnable;
    boardPkg::boxAddress_t writeAddress;
    logic [boardPkg::ColourWidth-1:0] writeColour;
    // writer and rasterizer to scanner handshake
    logic sweepStart;
    logic frameDone;
    // scanner to memory
    logic readEnable;
    boardPkg::boxAddress_t readAddress;
    logic [boardPkg::ColourWidth-1:0] readColour;
    // scanner to rasterizer, credit based
    logic boxValid;
    boardPkg::boxAddress_t boxAddress;
    logic [boardPkg::ColourWidth-1:0] boxColour;
    logic boxCredit;

    ////////////////////////////////////////
    // pipeline stages
    ////////////////////////////////////////

    positionWriter u_positionWriter (
        .clock(clock),
        .reset(reset),
        .redX(redX),
        .redY(redY),
        .blueX(blueX),
        .blueY(blueY),
        .frameDone(frameDone),
        .writeEnable(writeEnable),
        .writeAddress(writeAddress),
        .writeColour(writeColour),
        .sweepStart(sweepStart)
    );

    boardMemory u_boardMemory (
        .clock(clock),
        .reset(reset),
        .writeEnable(writeEnable),
        .writeAddress(writeAddress),
        .writeColour(writeColour),
        .readEnable(readEnable),
        .readAddress(readAddress),
        .readColour(readColour)
    );

    boxScanner u_boxScanner (
        .clock(clock),
        .reset(reset),
        .sweepStart(sweepStart),
        .readColour(readColour),
        .boxCredit(boxCredit),
        .readEnable(readEnable),
        .readAddress(readAddress),
        .boxValid(boxValid),
        .boxAddress(boxAddress),
        .boxColour(boxColour)
    );

    // sink credit depth set here
    boxRasterizer #(
        .PixelCredits(PixelCredits)
    ) u_boxRasterizer (
        .clock(clock),
        .reset(reset),
        .boxValid(boxValid),
        .boxAddress(boxAddress),
        .boxColour(boxColour),
        .pixelCredit(pixelCredit),
        .boxCredit(boxCredit),
        .frameDone(frameDone),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .endOfFrame(endOfFrame)
    );

endmodule

`default_nettype wire

// ==== src/boxRasterizer.sv ====
// PixelCredits of 1 or more; sink must return exactly one credit per accepted pixel
`default_nettype none
`timescale 1ns/100ps

module boxRasterizer #(
    parameter int PixelCredits = 4
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 boxValid,
    input  boardPkg::boxAddress_t                boxAddress,
    input  logic [boardPkg::ColourWidth-1:0]     boxColour,
    input  logic                                 pixelCredit,
    output logic                                 boxCredit,
    output logic                                 frameDone,
    output logic                                 pixelValid,
    output logic [boardPkg::PixelWidth-1:0]      pixelX,
    output logic [boardPkg::PixelWidth-1:0]      pixelY,
    output logic [boardPkg::ColourWidth-1:0]     pixelColour,
    output logic                                 endOfFrame
);

    localparam int CreditWidth = $clog2(PixelCredits + 1);
    localparam int InnerWidth = $clog2(boardPkg::BoxSize);
    localparam int CoordWidth = boardPkg::PixelWidth;
    localparam logic [InnerWidth-1:0] LastInner = InnerWidth'(boardPkg::BoxSize - 1);
    localparam logic [boardPkg::PosWidth-1:0] LastSide =
        boardPkg::PosWidth'(boardPkg::BoardSize - 1);

    // two-slot box queue
    boardPkg::boxAddress_t slotAddress [2];
    logic [boardPkg::ColourWidth-1:0] slotColour [2];
    logic headPtr;
    logic tailPtr;
    logic [1:0] slotCount;

    logic [CreditWidth-1:0] credits;
    logic [InnerWidth-1:0] innerColumn;
    logic [InnerWidth-1:0] innerRow;
    boardPkg::boxAddress_t headAddress;
    logic emit;
    logic boxEnd;

    ////////////////////////////////////////
    // queue
    ////////////////////////////////////////

    // payload only, slotCount says what is live
    always_ff @(posedge clock) begin
        if (boxValid) begin
            slotAddress[tailPtr] <= boxAddress;
            slotColour[tailPtr] <= boxColour;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= 1'b0;
            tailPtr <= 1'b0;
            slotCount <= 2'd0;
        end else begin
            if (boxValid) begin
                tailPtr <= ~tailPtr;
            end
            // head box retires with its 100th pixel
            if (boxCredit) begin
                headPtr <= ~headPtr;
            end
            slotCount <= slotCount + {1'b0, boxValid} - {1'b0, boxCredit};
        end
    end

    assign headAddress = slotAddress[headPtr];

    ////////////////////////////////////////
    // pixel stepping
    ////////////////////////////////////////

    // head box present and a sink credit left
    assign emit = (slotCount != 2'd0) && (credits != '0);
    assign boxEnd = (innerColumn == LastInner) && (innerRow == LastInner);

    // column first, then row; held while no pixel goes out
    always_ff @(posedge clock) begin
        if (reset) begin
            innerColumn <= '0;
            innerRow <= '0;
        end else if (emit) begin
            if (innerColumn == LastInner) begin
                innerColumn <= '0;
                innerRow <= (innerRow == LastInner) ? '0 : innerRow + 1'b1;
            end else begin
                innerColumn <= innerColumn + 1'b1;
            end
        end
    end

    // one spent per pixel, one back per sink credit
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CreditWidth'(PixelCredits);
        end else begin
            credits <= credits + CreditWidth'(pixelCredit) - CreditWidth'(emit);
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign pixelValid = emit;
    // box origin plus offset inside the box
    assign pixelX = CoordWidth'(headAddress.field.column) * CoordWidth'(boardPkg::BoxSize)
                    + CoordWidth'(innerColumn);
    assign pixelY = CoordWidth'(headAddress.field.row) * CoordWidth'(boardPkg::BoxSize)
                    + CoordWidth'(innerRow);
    assign pixelColour = slotColour[headPtr];

    assign boxCredit = emit && boxEnd;
    // bottom right box closes the frame
    assign endOfFrame = boxCredit && (headAddress.field.row == LastSide)
                        && (headAddress.field.column == LastSide);
    assign frameDone = endOfFrame;

endmodule

`default_nettype wire

// ==== src/boxScanner.sv ====
// sweeps boxes 0 to 255 once per sweepStart; at most two boxes are held between read and rasterizer
`default_nettype none
`timescale 1ns/100ps

module boxScanner (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 sweepStart,
    input  logic [boardPkg::ColourWidth-1:0]     readColour,
    input  logic                                 boxCredit,
    output logic                                 readEnable,
    output boardPkg::boxAddress_t                readAddress,
    output logic                                 boxValid,
    output boardPkg::boxAddress_t                boxAddress,
    output logic [boardPkg::ColourWidth-1:0]     boxColour
);

    // matches the two queue slots downstream
    localparam logic [1:0] BoxCredits = 2'd2;
    localparam int AddressWidth = $bits(boardPkg::boxAddress_t);
    localparam logic [AddressWidth-1:0] LastBox = AddressWidth'(boardPkg::BoxCount - 1);

    boardPkg::boxAddress_t counter;
    logic active;
    logic [1:0] credits;

    ////////////////////////////////////////
    // read issue
    ////////////////////////////////////////

    // one read per cycle while a credit is held
    assign readEnable = active && (credits != 2'd0);
    assign readAddress = counter;

    always_ff @(posedge clock) begin
        if (reset) begin
            active <= 1'b0;
            counter.index <= '0;
        end else if (sweepStart) begin
            active <= 1'b1;
            counter.index <= '0;
        end else if (readEnable) begin
            counter.index <= counter.index + 1'b1;
            // stop after the last box, counter wraps back to 0
            if (counter.index == LastBox) begin
                active <= 1'b0;
            end
        end
    end

    // credit taken at the read, so each boxValid is already paid for
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= BoxCredits;
        end else begin
            credits <= credits + {1'b0, boxCredit} - {1'b0, readEnable};
        end
    end

    ////////////////////////////////////////
    // pair address with returned colour
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            boxValid <= 1'b0;
        end else begin
            boxValid <= readEnable;
        end
    end

    // address delayed to line up with the memory latency
    always_ff @(posedge clock) begin
        if (readEnable) begin
            boxAddress <= readAddress;
        end
    end

    assign boxColour = readColour;

endmodule

`default_nettype wire

// ==== src/boardMemory.sv ====
// read and clear happen on one edge; a write and a read to the same box in one cycle keep the write
`default_nettype none
`timescale 1ns/100ps

module boardMemory (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 writeEnable,
    input  boardPkg::boxAddress_t                writeAddress,
    input  logic [boardPkg::ColourWidth-1:0]     writeColour,
    input  logic                                 readEnable,
    input  boardPkg::boxAddress_t                readAddress,
    output logic [boardPkg::ColourWidth-1:0]     readColour
);

    // one colour per box, flat index
    logic [boardPkg::ColourWidth-1:0] colours [boardPkg::BoxCount];

    ////////////////////////////////////////
    // store
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // whole board starts empty
            for (int i = 0; i < boardPkg::BoxCount; i++) begin
                colours[i] <= boardPkg::ColourNone;
            end
        end else begin
            // clear behind the read so stale players vanish next frame
            if (readEnable) begin
                colours[readAddress.index] <= boardPkg::ColourNone;
            end
            // write last, wins over the clear
            if (writeEnable) begin
                colours[writeAddress.index] <= writeColour;
            end
        end
    end

    // read data one cycle after the request
    always_ff @(posedge clock) begin
        if (readEnable) begin
            readColour <= colours[readAddress.index];
        end
    end

endmodule

`default_nettype wire

// ==== src/positionWriter.sv ====
// positions must hold from the sample cycle until the first pixel; a shared box is written as none
`default_nettype none
`timescale 1ns/100ps

module positionWriter (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [boardPkg::PosWidth-1:0]        redX,
    input  logic [boardPkg::PosWidth-1:0]        redY,
    input  logic [boardPkg::PosWidth-1:0]        blueX,
    input  logic [boardPkg::PosWidth-1:0]        blueY,
    input  logic                                 frameDone,
    output logic                                 writeEnable,
    output boardPkg::boxAddress_t                writeAddress,
    output logic [boardPkg::ColourWidth-1:0]     writeColour,
    output logic                                 sweepStart
);

    // one state per cycle of the write sequence
    localparam logic [2:0] Sample = 3'd0;
    localparam logic [2:0] WriteRed = 3'd1;
    localparam logic [2:0] WriteBlue = 3'd2;
    localparam logic [2:0] Start = 3'd3;
    localparam logic [2:0] Wait = 3'd4;

    logic [2:0] state;
    boardPkg::boxAddress_t redBox;
    boardPkg::boxAddress_t blueBox;
    logic collision;

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= Sample;
        end else begin
            case (state)
                Sample: state <= WriteRed;
                WriteRed: state <= WriteBlue;
                WriteBlue: state <= Start;
                Start: state <= Wait;
                // frame end restarts the sequence
                Wait: state <= frameDone ? Sample : Wait;
                default: state <= Sample;
            endcase
        end
    end

    // row in the upper nibble, column in the lower
    always_ff @(posedge clock) begin
        if (state == Sample) begin
            redBox.field.row <= redY;
            redBox.field.column <= redX;
            blueBox.field.row <= blueY;
            blueBox.field.column <= blueX;
        end
    end

    assign collision = (redBox.index == blueBox.index);

    ////////////////////////////////////////
    // write port and sweep start
    ////////////////////////////////////////

    always_comb begin
        writeEnable = 1'b0;
        writeAddress = redBox;
        writeColour = boardPkg::ColourNone;
        sweepStart = 1'b0;
        case (state)
            WriteRed: begin
                writeEnable = 1'b1;
                writeColour = collision ? boardPkg::ColourNone : boardPkg::ColourRed;
            end
            WriteBlue: begin
                writeEnable = 1'b1;
                writeAddress = blueBox;
                writeColour = collision ? boardPkg::ColourNone : boardPkg::ColourBlue;
            end
            Start: sweepStart = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/boardPkg.sv ====
// board geometry, colour codes and the box address; pixel coordinates assume a 16 x 16 board of 10 px boxes
`default_nettype none

package boardPkg;

    ////////////////////////////////////////
    // board geometry
    ////////////////////////////////////////

    // boxes per board side
    localparam int BoardSize = 16;
    // pixels per box side
    localparam int BoxSize = 10;
    // boxes per board
    localparam int BoxCount = BoardSize * BoardSize;
    // bits of a player column or row
    localparam int PosWidth = 4;
    // bits of a pixel coordinate, covers 0..159
    localparam int PixelWidth = 9;

    ////////////////////////////////////////
    // colours
    ////////////////////////////////////////

    localparam int ColourWidth = 3;
    // shared box and cleared entries both read as none
    localparam logic [ColourWidth-1:0] ColourNone = 3'b000;
    localparam logic [ColourWidth-1:0] ColourRed = 3'b100;
    localparam logic [ColourWidth-1:0] ColourBlue = 3'b001;

    // scanner counts the flat index, rasterizer splits row and column
    typedef union packed {
        logic [2*PosWidth-1:0] index;
        struct packed {
            logic [PosWidth-1:0] row;
            logic [PosWidth-1:0] column;
        } field;
    } boxAddress_t;

endpackage

`default_nettype wire
